// ==== rtl/csr_consts.svh ====
// Widths, queue depth and CSR addresses shared by the CSR pipe.
// CSR_QUEUE_DEPTH must stay a power of two because the queue pointers wrap freely.
// Only the five machine CSRs listed here exist. Any other address is illegal.

`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// data path width of the integer file and of every CSR.
`define XLEN 64

// number of integer registers and the width of their index.
`define GPR_NUM   32
`define GPR_IDX_W 5

// entries in the in-order issue queue.
`define CSR_QUEUE_DEPTH 4

// CSR address space.
`define CSR_ADDR_W 12
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MHARTID  12'hF14

`endif

// ==== rtl/csr_pkg.sv ====
// Types for Zicsr instructions and the CSR address space.
// Opcode encodings follow the funct3 field, so bit 2 marks the immediate forms.

`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

	////////////////////////////////////////////////////////////////////////////
	// instruction opcodes
	////////////////////////////////////////////////////////////////////////////

	// the six Zicsr forms, coded as their funct3 value.
	// the immediate forms carry a 5-bit uimm in place of rs1.
	typedef enum logic [2:0] {
		CSRRW  = 3'b001,
		CSRRS  = 3'b010,
		CSRRC  = 3'b011,
		CSRRWI = 3'b101,
		CSRRSI = 3'b110,
		CSRRCI = 3'b111
	} csr_op_e;

	////////////////////////////////////////////////////////////////////////////
	// execute function
	////////////////////////////////////////////////////////////////////////////

	// the read-modify-write operation once the operand source is resolved.
	typedef enum logic [1:0] {
		CSR_FN_WRITE = 2'd0,
		CSR_FN_SET   = 2'd1,
		CSR_FN_CLEAR = 2'd2
	} csr_fn_e;

	// a 12-bit CSR address as found in the instruction.
	typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

endpackage

`default_nettype wire

// ==== rtl/reg_pkg.sv ====
// Types for the integer register file.
// xdata_t is also used for CSR values and program counters.

`default_nettype none

`include "csr_consts.svh"

package reg_pkg;

	// index of one of the integer registers, x0 included.
	typedef logic [`GPR_IDX_W-1:0] reg_idx_t;

	// one register or CSR value.
	typedef logic [`XLEN-1:0] xdata_t;

endpackage

`default_nettype wire

// ==== rtl/csr_issue_fifo.sv ====
// In-order queue of dispatched CSR instructions.
// Depth comes from CSR_QUEUE_DEPTH and must be a power of two.
// in_ready drops while full or during flush, so a push never overflows or is lost.

`default_nettype none

`include "csr_consts.svh"

module csr_issue_fifo
	import csr_pkg::*;
	import reg_pkg::*;
(
	input  wire logic      CLK,
	input  wire logic      rst,
	input  wire logic      flush,
	input  wire logic      in_valid,
	input  csr_op_e        in_op,
	input  xdata_t         in_pc,
	input  csr_addr_t      in_addr,
	input  reg_idx_t       in_rd,
	input  reg_idx_t       in_rs1,
	output logic           in_ready,
	input  wire logic      pop,
	output logic           empty,
	output csr_op_e        head_op,
	output xdata_t         head_pc,
	output csr_addr_t      head_addr,
	output reg_idx_t       head_rd,
	output reg_idx_t       head_rs1
);

	localparam int DEPTH = `CSR_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	// one array per field keeps the head decode simple.
	csr_op_e   op_mem   [DEPTH];
	xdata_t    pc_mem   [DEPTH];
	csr_addr_t addr_mem [DEPTH];
	reg_idx_t  rd_mem   [DEPTH];
	reg_idx_t  rs1_mem  [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             push;

	// a dispatch offered during flush is held off rather than dropped.
	assign in_ready = (count != (PTR_W + 1)'(DEPTH)) && !flush;
	assign push     = in_valid && in_ready;
	assign empty    = (count == '0);

	// the head is always the entry under the read pointer.
	assign head_op   = op_mem[rd_ptr];
	assign head_pc   = pc_mem[rd_ptr];
	assign head_addr = addr_mem[rd_ptr];
	assign head_rd   = rd_mem[rd_ptr];
	assign head_rs1  = rs1_mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (push) begin
			op_mem[wr_ptr]   <= in_op;
			pc_mem[wr_ptr]   <= in_pc;
			addr_mem[wr_ptr] <= in_addr;
			rd_mem[wr_ptr]   <= in_rd;
			rs1_mem[wr_ptr]  <= in_rs1;
		end
	end

	// flush only moves the pointers; stale entries are simply never read.
	always_ff @(posedge CLK) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop on the same edge leave the count alone.
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/gpr_file.sv ====
// Integer register file, 32 x XLEN, with a pending log for RAW checks.
// x0 reads zero and is never written. Reads are combinational.
// The external port writes only data and is meant for preload while the pipe is idle.

`default_nettype none

`include "csr_consts.svh"

module gpr_file
	import reg_pkg::*;
(
	input  wire logic CLK,
	input  wire logic rst,
	input  reg_idx_t  rs_idx,
	output xdata_t    rs_data,
	output logic      rs_pending,
	input  wire logic set_valid,
	input  reg_idx_t  set_idx,
	input  wire logic wb_valid,
	input  reg_idx_t  wb_rd,
	input  xdata_t    wb_data,
	input  wire logic wb_illegal,
	input  wire logic ext_valid,
	input  reg_idx_t  ext_idx,
	input  xdata_t    ext_data,
	input  reg_idx_t  dbg_idx,
	output xdata_t    dbg_data
);

	xdata_t                regs [`GPR_NUM];
	logic [`GPR_NUM-1:0]   pending;
	logic                  wb_write;

	// a legal writeback to a real register updates it.
	assign wb_write = wb_valid && !wb_illegal && (wb_rd != '0);

	////////////////////////////////////////////////////////////////////////////
	// read ports
	////////////////////////////////////////////////////////////////////////////

	// x0 is forced to zero here as well as never being written.
	assign rs_data    = (rs_idx == '0) ? '0 : regs[rs_idx];
	assign rs_pending = pending[rs_idx];
	assign dbg_data   = (dbg_idx == '0) ? '0 : regs[dbg_idx];

	////////////////////////////////////////////////////////////////////////////
	// register array
	////////////////////////////////////////////////////////////////////////////

	// the file comes out of reset as all zeros.
	// the writeback port wins over the external port on the same index.
	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < `GPR_NUM; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (ext_valid && (ext_idx != '0)) begin
				regs[ext_idx] <= ext_data;
			end
			if (wb_write) begin
				regs[wb_rd] <= wb_data;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pending log
	////////////////////////////////////////////////////////////////////////////

	// a bit is raised at issue and dropped at writeback, legal or not.
	// set is applied last so a newer issue to the same rd is not lost.
	// x0 never goes pending since it always holds zero.
	always_ff @(posedge CLK) begin
		if (rst) begin
			pending <= '0;
		end else begin
			if (wb_valid) begin
				pending[wb_rd] <= 1'b0;
			end
			if (set_valid && (set_idx != '0)) begin
				pending[set_idx] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/csr_issue.sv ====
// Issue stage of the CSR pipe.
// The head issues only when it is the oldest uncommitted instruction, its rs1
// is not pending and no flush is active. Execute never stalls, so a fire always
// hands the instruction on.

`default_nettype none

module csr_issue
	import csr_pkg::*;
	import reg_pkg::*;
(
	input  wire logic CLK,
	input  wire logic rst,
	input  wire logic flush,
	input  wire logic empty,
	input  csr_op_e   head_op,
	input  xdata_t    head_pc,
	input  csr_addr_t head_addr,
	input  reg_idx_t  head_rd,
	input  reg_idx_t  head_rs1,
	output logic      pop,
	input  xdata_t    commit_pc,
	output reg_idx_t  rs_idx,
	input  xdata_t    rs_data,
	input  wire logic rs_pending,
	output logic      set_valid,
	output reg_idx_t  set_idx,
	output logic      exe_valid,
	output csr_fn_e   exe_fn,
	output xdata_t    exe_operand,
	output csr_addr_t exe_addr,
	output reg_idx_t  exe_rd,
	output xdata_t    exe_pc,
	output logic      exe_nowrite
);

	logic    is_imm;
	csr_fn_e fn;
	xdata_t  operand;
	logic    rs1_ready;
	logic    in_order;
	logic    fire;

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////

	// the register and immediate forms share one function each.
	always_comb begin
		is_imm = 1'b0;
		fn     = CSR_FN_WRITE;
		case (head_op)
			CSRRW:  fn = CSR_FN_WRITE;
			CSRRS:  fn = CSR_FN_SET;
			CSRRC:  fn = CSR_FN_CLEAR;
			CSRRWI: begin
				is_imm = 1'b1;
				fn     = CSR_FN_WRITE;
			end
			CSRRSI: begin
				is_imm = 1'b1;
				fn     = CSR_FN_SET;
			end
			CSRRCI: begin
				is_imm = 1'b1;
				fn     = CSR_FN_CLEAR;
			end
			default: fn = CSR_FN_WRITE;
		endcase
	end

	// the rs1 field doubles as the uimm for the immediate forms.
	assign rs_idx  = head_rs1;
	assign operand = is_imm ? xdata_t'(head_rs1) : rs_data;

	////////////////////////////////////////////////////////////////////////////
	// issue condition
	////////////////////////////////////////////////////////////////////////////

	// an immediate or x0 source has nothing to wait for.
	assign rs1_ready = is_imm || (head_rs1 == '0) || !rs_pending;

	// CSRs are not renamed, so every older instruction must have committed.
	assign in_order = (commit_pc == head_pc);

	assign fire = !empty && rs1_ready && in_order && !flush;

	// the queue drops the head on the same edge that the rd goes pending.
	assign pop       = fire;
	assign set_valid = fire;
	assign set_idx   = head_rd;

	// execute valid lasts one cycle per fire; flush is already folded into fire.
	always_ff @(posedge CLK) begin
		if (rst) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= fire;
		end
	end

	// execute parameters are only meaningful while exe_valid is high.
	always_ff @(posedge CLK) begin
		if (fire) begin
			exe_fn      <= fn;
			exe_operand <= operand;
			exe_addr    <= head_addr;
			exe_rd      <= head_rd;
			exe_pc      <= head_pc;
			// set or clear by a zero field only reads the CSR.
			exe_nowrite <= (fn != CSR_FN_WRITE) && (head_rs1 == '0);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/csr_exec.sv ====
// Execute stage: the CSR file and its read-modify-write.
// Only mscratch, mtvec, mepc and mcause are writable; mhartid reads zero (one hart).
// An illegal access leaves every CSR untouched and returns zero data.

`default_nettype none

`include "csr_consts.svh"

module csr_exec
	import csr_pkg::*;
	import reg_pkg::*;
(
	input  wire logic CLK,
	input  wire logic rst,
	input  wire logic exe_valid,
	input  csr_fn_e   exe_fn,
	input  xdata_t    exe_operand,
	input  csr_addr_t exe_addr,
	input  reg_idx_t  exe_rd,
	input  xdata_t    exe_pc,
	input  wire logic exe_nowrite,
	output logic      wb_valid,
	output reg_idx_t  wb_rd,
	output xdata_t    wb_data,
	output logic      wb_illegal,
	output xdata_t    wb_pc
);

	xdata_t mscratch;
	xdata_t mtvec;
	xdata_t mepc;
	xdata_t mcause;

	logic   sel_mscratch;
	logic   sel_mtvec;
	logic   sel_mepc;
	logic   sel_mcause;
	logic   sel_mhartid;
	logic   known;
	logic   illegal;
	logic   do_write;
	xdata_t old_val;
	xdata_t new_val;

	////////////////////////////////////////////////////////////////////////////
	// address decode and read
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		sel_mscratch = 1'b0;
		sel_mtvec    = 1'b0;
		sel_mepc     = 1'b0;
		sel_mcause   = 1'b0;
		sel_mhartid  = 1'b0;
		known        = 1'b1;
		old_val      = '0;
		case (exe_addr)
			`CSR_ADDR_MSCRATCH: begin
				sel_mscratch = 1'b1;
				old_val      = mscratch;
			end
			`CSR_ADDR_MTVEC: begin
				sel_mtvec = 1'b1;
				old_val   = mtvec;
			end
			`CSR_ADDR_MEPC: begin
				sel_mepc = 1'b1;
				old_val  = mepc;
			end
			`CSR_ADDR_MCAUSE: begin
				sel_mcause = 1'b1;
				old_val    = mcause;
			end
			// hart zero is the only hart, so the id is a constant zero.
			`CSR_ADDR_MHARTID: sel_mhartid = 1'b1;
			default:           known = 1'b0;
		endcase
	end

	// the modify step is the same for all writable CSRs.
	always_comb begin
		case (exe_fn)
			CSR_FN_SET:   new_val = old_val | exe_operand;
			CSR_FN_CLEAR: new_val = old_val & ~exe_operand;
			default:      new_val = exe_operand;
		endcase
	end

	// mhartid is read-only; only a suppressed write to it is legal.
	assign illegal  = !known || (sel_mhartid && !exe_nowrite);
	assign do_write = exe_valid && !illegal && !exe_nowrite;

	////////////////////////////////////////////////////////////////////////////
	// CSR file
	////////////////////////////////////////////////////////////////////////////

	// the writable CSRs start from zero.
	always_ff @(posedge CLK) begin
		if (rst) begin
			mscratch <= '0;
			mtvec    <= '0;
			mepc     <= '0;
			mcause   <= '0;
		end else if (do_write) begin
			if (sel_mscratch) begin
				mscratch <= new_val;
			end
			if (sel_mtvec) begin
				mtvec <= new_val;
			end
			if (sel_mepc) begin
				mepc <= new_val;
			end
			if (sel_mcause) begin
				mcause <= new_val;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// writeback register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid;
		end
	end

	// rd gets the value seen before the modify.
	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			wb_rd      <= exe_rd;
			wb_pc      <= exe_pc;
			wb_illegal <= illegal;
			wb_data    <= illegal ? '0 : old_val;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/csr_unit.sv ====
// Top level of the CSR pipe: queue, issue, execute and the integer file.
// Dispatch must hold its inputs until taken. The gpr_wr port is for preload
// while the pipe is idle only.

`default_nettype none

module csr_unit
	import csr_pkg::*;
	import reg_pkg::*;
(
	input  wire logic CLK,
	input  wire logic rst,
	input  wire logic dispatch_valid,
	input  csr_op_e   dispatch_op,
	input  xdata_t    dispatch_pc,
	input  csr_addr_t dispatch_addr,
	input  reg_idx_t  dispatch_rd,
	input  reg_idx_t  dispatch_rs1,
	output logic      dispatch_ready,
	input  xdata_t    commit_pc,
	input  wire logic flush,
	input  wire logic gpr_wr_valid,
	input  reg_idx_t  gpr_wr_idx,
	input  xdata_t    gpr_wr_data,
	input  reg_idx_t  gpr_rd_idx,
	output xdata_t    gpr_rd_data,
	output logic      wb_valid,
	output reg_idx_t  wb_rd,
	output xdata_t    wb_data,
	output logic      wb_illegal,
	output xdata_t    wb_pc
);

	// queue head towards issue.
	logic      fifo_empty;
	logic      fifo_pop;
	csr_op_e   head_op;
	xdata_t    head_pc;
	csr_addr_t head_addr;
	reg_idx_t  head_rd;
	reg_idx_t  head_rs1;

	// operand read and pending set between issue and the integer file.
	reg_idx_t  rs_idx;
	xdata_t    rs_data;
	logic      rs_pending;
	logic      set_valid;
	reg_idx_t  set_idx;

	// execute parameters.
	logic      exe_valid;
	csr_fn_e   exe_fn;
	xdata_t    exe_operand;
	csr_addr_t exe_addr;
	reg_idx_t  exe_rd;
	xdata_t    exe_pc;
	logic      exe_nowrite;

	csr_issue_fifo u_fifo (
		.CLK(CLK), .rst(rst), .flush(flush),
		.in_valid(dispatch_valid), .in_op(dispatch_op), .in_pc(dispatch_pc),
		.in_addr(dispatch_addr), .in_rd(dispatch_rd), .in_rs1(dispatch_rs1),
		.in_ready(dispatch_ready), .pop(fifo_pop), .empty(fifo_empty),
		.head_op(head_op), .head_pc(head_pc), .head_addr(head_addr),
		.head_rd(head_rd), .head_rs1(head_rs1)
	);

	csr_issue u_issue (
		.CLK(CLK), .rst(rst), .flush(flush), .empty(fifo_empty),
		.head_op(head_op), .head_pc(head_pc), .head_addr(head_addr),
		.head_rd(head_rd), .head_rs1(head_rs1), .pop(fifo_pop),
		.commit_pc(commit_pc), .rs_idx(rs_idx), .rs_data(rs_data),
		.rs_pending(rs_pending), .set_valid(set_valid), .set_idx(set_idx),
		.exe_valid(exe_valid), .exe_fn(exe_fn), .exe_operand(exe_operand),
		.exe_addr(exe_addr), .exe_rd(exe_rd), .exe_pc(exe_pc),
		.exe_nowrite(exe_nowrite)
	);

	csr_exec u_exec (
		.CLK(CLK), .rst(rst), .exe_valid(exe_valid), .exe_fn(exe_fn),
		.exe_operand(exe_operand), .exe_addr(exe_addr), .exe_rd(exe_rd),
		.exe_pc(exe_pc), .exe_nowrite(exe_nowrite), .wb_valid(wb_valid),
		.wb_rd(wb_rd), .wb_data(wb_data), .wb_illegal(wb_illegal), .wb_pc(wb_pc)
	);

	// writeback both leaves the unit and retires rd in the integer file.
	gpr_file u_gpr (
		.CLK(CLK), .rst(rst), .rs_idx(rs_idx), .rs_data(rs_data),
		.rs_pending(rs_pending), .set_valid(set_valid), .set_idx(set_idx),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.wb_illegal(wb_illegal), .ext_valid(gpr_wr_valid), .ext_idx(gpr_wr_idx),
		.ext_data(gpr_wr_data), .dbg_idx(gpr_rd_idx), .dbg_data(gpr_rd_data)
	);

endmodule

`default_nettype wire

// ==== verif/tb_csr_unit.sv ====
// Random-stimulus testbench for the CSR pipe, checked against a reference model.
// The testbench acts as commit and moves commit_pc as soon as it sees a writeback,
// so the next instruction may issue on the edge that retires the previous one.
// Stimulus uses a fixed seed.

`default_nettype none

`include "csr_consts.svh"

module tb_csr_unit
	import csr_pkg::*;
	import reg_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RANDOM  = 40;
	localparam int N_RAW     = 16;
	localparam int N_ILLEGAL = 24;
	localparam int N_BURST   = 3 * `CSR_QUEUE_DEPTH;
	localparam int N_FLUSH   = 10;
	localparam int N_DOOMED  = `CSR_QUEUE_DEPTH;
	// each test but the reset check ends with a read of the four writable CSRs.
	// the illegal test adds one legal read of mhartid.
	localparam int N_TOTAL = N_RANDOM + N_RAW + N_ILLEGAL + N_BURST + N_FLUSH + N_DOOMED + 21;
	// 20 cycles per instruction, plus reset and register preload time.
	localparam int WATCHDOG_CYCLES = N_TOTAL * 20 + 500;

	localparam csr_op_e OPS [6] = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
	localparam csr_addr_t WRITABLE [4] = '{`CSR_ADDR_MSCRATCH, `CSR_ADDR_MTVEC,
		`CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE};

	logic      CLK;
	logic      rst;
	logic      dispatch_valid;
	csr_op_e   dispatch_op;
	xdata_t    dispatch_pc;
	csr_addr_t dispatch_addr;
	reg_idx_t  dispatch_rd;
	reg_idx_t  dispatch_rs1;
	logic      dispatch_ready;
	xdata_t    commit_pc;
	logic      flush;
	logic      gpr_wr_valid;
	reg_idx_t  gpr_wr_idx;
	xdata_t    gpr_wr_data;
	reg_idx_t  gpr_rd_idx;
	xdata_t    gpr_rd_data;
	logic      wb_valid;
	reg_idx_t  wb_rd;
	xdata_t    wb_data;
	logic      wb_illegal;
	xdata_t    wb_pc;

	// model state; slot 4 of the CSR array is mhartid and stays zero.
	xdata_t    model_gpr [32];
	xdata_t    model_csr [5];
	// dispatched instructions still waiting for their writeback, oldest first.
	csr_op_e   exp_op [$];
	csr_addr_t exp_addr [$];
	reg_idx_t  exp_rd [$];
	reg_idx_t  exp_rs1 [$];
	xdata_t    exp_pc [$];

	logic [63:0] rng_state;
	xdata_t      next_pc;
	logic        saw_full;
	int          n_pass;
	int          n_fail;
	int          test_pass0;
	int          test_fail0;

	csr_unit dut0 (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers and checks
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [63:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 7);
		rng_state = rng_state ^ (rng_state << 17);
		return rng_state;
	endfunction

	function automatic csr_op_e rand_op();
		return OPS[int'(next_rand() % 6)];
	endfunction

	function automatic csr_addr_t rand_csr();
		return WRITABLE[2'(next_rand())];
	endfunction

	function automatic reg_idx_t rand_reg();
		return reg_idx_t'(next_rand());
	endfunction

	// model slot of a CSR address, or -1 for an address that does not exist.
	function automatic int csr_slot(input csr_addr_t addr);
		case (addr)
			`CSR_ADDR_MSCRATCH: return 0;
			`CSR_ADDR_MTVEC:    return 1;
			`CSR_ADDR_MEPC:     return 2;
			`CSR_ADDR_MCAUSE:   return 3;
			`CSR_ADDR_MHARTID:  return 4;
			default:            return -1;
		endcase
	endfunction

	task automatic check_data(input string name, input xdata_t got, input xdata_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0d ns: %s got %b expected %b", $time, name, got, exp);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		n_fail++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// writeback monitor and commit
	////////////////////////////////////////////////////////////////////////////

	// applies the oldest instruction to the model and compares the writeback.
	// called just after the edge that raised wb_valid.
	task automatic retire_one();
		csr_op_e  op;
		reg_idx_t rd;
		reg_idx_t rs1;
		xdata_t   pc;
		int       slot;
		logic     nowrite;
		logic     illegal;
		xdata_t   operand;
		xdata_t   old_val;
		xdata_t   new_val;
		if (exp_pc.size() == 0) begin
			report_error($sformatf("writeback from pc %h with nothing outstanding", wb_pc));
			return;
		end
		op   = exp_op[0];
		rd   = exp_rd[0];
		rs1  = exp_rs1[0];
		pc   = exp_pc[0];
		slot = csr_slot(exp_addr[0]);
		// the immediate forms take the rs1 field itself, zero-extended.
		if ((op == CSRRWI) || (op == CSRRSI) || (op == CSRRCI)) begin
			operand = xdata_t'(rs1);
		end else begin
			operand = model_gpr[rs1];
		end
		nowrite = (op != CSRRW) && (op != CSRRWI) && (rs1 == '0);
		illegal = (slot < 0) || ((slot == 4) && !nowrite);
		old_val = '0;
		if (!illegal) begin
			old_val = model_csr[slot];
		end
		case (op)
			CSRRS, CSRRSI: new_val = old_val | operand;
			CSRRC, CSRRCI: new_val = old_val & ~operand;
			default:       new_val = operand;
		endcase
		if (!illegal && !nowrite) begin
			model_csr[slot] = new_val;
		end
		if (!illegal && (rd != '0)) begin
			model_gpr[rd] = old_val;
		end
		check_data("wb_pc", wb_pc, pc);
		check_idx("wb_rd", wb_rd, rd);
		check_flag("wb_illegal", wb_illegal, illegal);
		check_data("wb_data", wb_data, old_val);
		// commit now, so a dependent instruction can only go once the pending bit clears.
		commit_pc = pc + 64'd4;
		@(posedge CLK);
		#1;
		gpr_rd_idx = rd;
		@(negedge CLK);
		check_data("gpr_rd_data", gpr_rd_data, model_gpr[rd]);
		// the next pc was committed after the edge that started this writeback,
		// so nothing can have issued in time to write back yet.
		check_flag("wb_valid", wb_valid, 1'b0);
		void'(exp_op.pop_front());
		void'(exp_addr.pop_front());
		void'(exp_rd.pop_front());
		void'(exp_rs1.pop_front());
		void'(exp_pc.pop_front());
	endtask

	initial begin
		forever begin
			@(posedge CLK);
			#1;
			if (wb_valid === 1'b1) begin
				retire_one();
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("ERROR at %0d ns: watchdog expired, the CSR pipe hung with %0d outstanding",
			$time, exp_pc.size());
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	// holds the instruction until dispatch_ready is seen high at a clock edge.
	task automatic dispatch_one(input csr_op_e op, input csr_addr_t addr, input reg_idx_t rd,
		input reg_idx_t rs1, input xdata_t pc, input logic track);
		logic taken;
		taken          = 1'b0;
		dispatch_valid = 1'b1;
		dispatch_op    = op;
		dispatch_addr  = addr;
		dispatch_rd    = rd;
		dispatch_rs1   = rs1;
		dispatch_pc    = pc;
		while (!taken) begin
			@(negedge CLK);
			taken = dispatch_ready;
			if (!taken) begin
				saw_full = 1'b1;
			end
			@(posedge CLK);
			#1;
		end
		dispatch_valid = 1'b0;
		if (track) begin
			exp_op.push_back(op);
			exp_addr.push_back(addr);
			exp_rd.push_back(rd);
			exp_rs1.push_back(rs1);
			exp_pc.push_back(pc);
		end
	endtask

	task automatic issue_instr(input csr_op_e op, input csr_addr_t addr, input reg_idx_t rd,
		input reg_idx_t rs1);
		dispatch_one(op, addr, rd, rs1, next_pc, 1'b1);
		next_pc = next_pc + 64'd4;
	endtask

	task automatic wait_idle();
		do begin
			@(posedge CLK);
		end while (exp_pc.size() != 0);
		#1;
	endtask

	task automatic preload_gprs();
		for (int i = 1; i < 32; i++) begin
			gpr_wr_valid = 1'b1;
			gpr_wr_idx   = reg_idx_t'(i);
			gpr_wr_data  = next_rand();
			model_gpr[i] = gpr_wr_data;
			@(posedge CLK);
			#1;
		end
		gpr_wr_valid = 1'b0;
	endtask

	// CSRRS with rs1 zero only reads, so this shows the current CSR values.
	task automatic read_back_csrs();
		for (int s = 0; s < 4; s++) begin
			issue_instr(CSRRS, WRITABLE[s], reg_idx_t'(1 + next_rand() % 31), '0);
		end
		wait_idle();
	endtask

	task automatic end_test(input string name);
		$display("test %-8s done: %0d checks passed, %0d failed", name,
			n_pass - test_pass0, n_fail - test_fail0);
		test_pass0 = n_pass;
		test_fail0 = n_fail;
	endtask

	initial begin
		csr_addr_t addr;
		reg_idx_t  prev;
		reg_idx_t  rd;
		rng_state      = 64'd41091;
		n_pass         = 0;
		n_fail         = 0;
		test_pass0     = 0;
		test_fail0     = 0;
		saw_full       = 1'b0;
		next_pc        = 64'h1000;
		commit_pc      = 64'h1000;
		rst            = 1'b1;
		flush          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_op    = CSRRW;
		dispatch_pc    = '0;
		dispatch_addr  = '0;
		dispatch_rd    = '0;
		dispatch_rs1   = '0;
		gpr_wr_valid   = 1'b0;
		gpr_wr_idx     = '0;
		gpr_wr_data    = '0;
		gpr_rd_idx     = '0;
		for (int i = 0; i < 32; i++) begin
			model_gpr[i] = '0;
		end
		for (int i = 0; i < 5; i++) begin
			model_csr[i] = '0;
		end
		repeat (10) @(posedge CLK);
		#1;
		rst = 1'b0;
		@(negedge CLK);
		check_flag("dispatch_ready", dispatch_ready, 1'b1);
		check_flag("wb_valid", wb_valid, 1'b0);
		@(posedge CLK);
		#1;
		end_test("reset");

		// every opcode on the writable CSRs with random sources.
		preload_gprs();
		for (int i = 0; i < N_RANDOM; i++) begin
			issue_instr(rand_op(), rand_csr(), rand_reg(), rand_reg());
		end
		read_back_csrs();
		end_test("random");

		// each source register is the previous destination.
		preload_gprs();
		prev = rand_reg();
		for (int i = 0; i < N_RAW; i++) begin
			rd = reg_idx_t'(1 + next_rand() % 31);
			issue_instr(OPS[int'(next_rand() % 3)], rand_csr(), rd, prev);
			prev = rd;
		end
		read_back_csrs();
		end_test("raw");

		// unknown addresses alternate with accesses to the read-only mhartid.
		for (int i = 0; i < N_ILLEGAL; i++) begin
			if (i % 2 == 0) begin
				do begin
					addr = csr_addr_t'(next_rand());
				end while (csr_slot(addr) >= 0);
			end else begin
				addr = `CSR_ADDR_MHARTID;
			end
			issue_instr(rand_op(), addr, rand_reg(), rand_reg());
		end
		issue_instr(CSRRS, `CSR_ADDR_MHARTID, 5'd7, '0);
		read_back_csrs();
		end_test("illegal");

		// a burst well past the queue depth has to stall dispatch.
		saw_full = 1'b0;
		for (int i = 0; i < N_BURST; i++) begin
			issue_instr(rand_op(), rand_csr(), rand_reg(), rand_reg());
		end
		wait_idle();
		if (!saw_full) begin
			report_error("dispatch_ready never dropped during the burst");
		end
		read_back_csrs();
		end_test("burst");

		// commit_pc never reaches these pcs, so they fill the queue until flushed.
		for (int i = 0; i < N_DOOMED; i++) begin
			dispatch_one(rand_op(), rand_csr(), rand_reg(), rand_reg(),
				64'h8000_0000 + 64'(4 * i), 1'b0);
		end
		flush = 1'b1;
		@(posedge CLK);
		#1;
		flush = 1'b0;
		@(negedge CLK);
		check_flag("dispatch_ready", dispatch_ready, 1'b1);
		@(posedge CLK);
		#1;
		for (int i = 0; i < N_FLUSH; i++) begin
			issue_instr(rand_op(), rand_csr(), rand_reg(), rand_reg());
		end
		read_back_csrs();
		end_test("flush");

		$display("%0d checks passed, %0d checks failed", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/csr_pkg.sv
rtl/reg_pkg.sv
rtl/csr_issue_fifo.sv
rtl/gpr_file.sv
rtl/csr_issue.sv
rtl/csr_exec.sv
rtl/csr_unit.sv
verif/tb_csr_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the CSR pipe testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_csr_unit \
	--Mdir obj_dir -o tb_csr_unit > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/tb_csr_unit > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$SIM_LOG"; then
	exit 1
fi
if ! grep -q "Simulation passed" "$SIM_LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0
